// ==== Bender.yml ====
package:
  name: dot_accel

sources:
  - files:
      - hdl/dot_pkg.sv
      - hdl/sync_fifo.sv
      - hdl/dot_engine.sv
      - hdl/dot_regs.sv
      - hdl/dot_top.sv

  - target: simulation
    files:
      - verif/dot_tb.sv

export_include_dirs: []

// ==== hdl/dot_engine.sv ====
`timescale 1ns/1ps

module dot_engine
    import dot_pkg::*;
(
    input  logic               clock,
    input  logic               reset,
    input  vec_pair_t          in_pair,
    input  logic               in_empty,
    output logic               in_rd_en,
    output logic signed [31:0] out_result,
    input  logic               out_full,
    output logic               out_wr_en
);

    typedef enum logic {idle, hold} state_t;

    state_t             state;
    state_t             next_state;
    logic signed [63:0] prod0;
    logic signed [63:0] prod1;
    logic signed [63:0] prod2;
    logic signed [63:0] sum;

    // full-width products are each rescaled before the sum.
    assign prod0 = in_pair.x.e0 * in_pair.y.e0;
    assign prod1 = in_pair.x.e1 * in_pair.y.e1;
    assign prod2 = in_pair.x.e2 * in_pair.y.e2;
    assign sum   = (prod0 >>> q_bits) + (prod1 >>> q_bits) + (prod2 >>> q_bits);

    always_comb begin
        next_state = state;
        in_rd_en   = 1'b0;
        out_wr_en  = 1'b0;
        case (state)
            idle: begin
                if (!in_empty) begin
                    in_rd_en   = 1'b1;
                    next_state = hold;
                end
            end
            hold: begin
                if (!out_full) begin
                    out_wr_en  = 1'b1;
                    next_state = idle;
                end
            end
            default: next_state = idle;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= idle;
        end else begin
            state <= next_state;
        end
    end

    // result is kept here until the output queue has room.
    always_ff @(posedge clock) begin
        if (in_rd_en) begin
            out_result <= $signed(sum[31:0]);
        end
    end

    a_wr_in_hold: assert property (@(posedge clock) disable iff (reset)
        out_wr_en |-> (state == hold) && !out_full && $past(in_rd_en || state == hold))
        else $error("engine wrote a result it never took");

endmodule

// ==== hdl/dot_pkg.sv ====
package dot_pkg;

    // fixed-point format of operands and results.
    localparam int q_bits = 10;

    // entries in each queue.
    localparam int fifo_depth = 8;

    // register word index, taken from adr[5:2].
    localparam logic [3:0] reg_x0     = 4'd0;
    localparam logic [3:0] reg_x1     = 4'd1;
    localparam logic [3:0] reg_x2     = 4'd2;
    localparam logic [3:0] reg_y0     = 4'd3;
    localparam logic [3:0] reg_y1     = 4'd4;
    localparam logic [3:0] reg_y2     = 4'd5;
    localparam logic [3:0] reg_push   = 4'd6;
    localparam logic [3:0] reg_status = 4'd7;
    localparam logic [3:0] reg_result = 4'd8;

    // bit positions in the status word.
    localparam int st_in_full   = 0;
    localparam int st_out_empty = 1;
    localparam int st_overflow  = 2;

    // one operand vector.
    typedef struct packed {
        logic signed [31:0] e2;
        logic signed [31:0] e1;
        logic signed [31:0] e0;
    } vec3_t;

    // payload of the input queue.
    typedef struct packed {
        vec3_t x;
        vec3_t y;
    } vec_pair_t;

    // wishbone classic request from host to slave.
    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [5:0]  adr;
        logic [31:0] dat_w;
        logic [3:0]  sel;
    } wb_req_t;

    // wishbone classic response from slave to host.
    typedef struct packed {
        logic        ack;
        logic [31:0] dat_r;
    } wb_rsp_t;

endpackage

// ==== hdl/dot_regs.sv ====
`timescale 1ns/1ps

module dot_regs
    import dot_pkg::*;
(
    input  logic        clock,
    input  logic        reset,
    input  wb_req_t     wb_req,
    output wb_rsp_t     wb_rsp,
    output logic        push_valid,
    output vec_pair_t   push_pair,
    input  logic        in_full,
    input  logic [31:0] out_head,
    input  logic        out_empty,
    output logic        out_rd_en
);

    logic        ack;
    logic [3:0]  word;
    logic        wr_cycle;
    logic        rd_cycle;
    logic        push_hit;
    logic        overflow;
    logic [31:0] status;
    logic [31:0] rd_data;
    vec3_t       x_reg;
    vec3_t       y_reg;

    // one ack per request and never two back to back.
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            ack <= 1'b0;
        end else begin
            ack <= wb_req.cyc && wb_req.stb && !ack;
        end
    end

    // the host holds its request through the ack cycle.
    assign word     = wb_req.adr[5:2];
    assign wr_cycle = ack && wb_req.we;
    assign rd_cycle = ack && !wb_req.we;
    assign push_hit = wr_cycle && (word == reg_push);

    assign push_valid = push_hit && !in_full;
    assign out_rd_en  = rd_cycle && (word == reg_result) && !out_empty;

    assign push_pair.x = x_reg;
    assign push_pair.y = y_reg;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            x_reg <= '0;
            y_reg <= '0;
        end else if (wr_cycle) begin
            case (word)
                reg_x0:  x_reg.e0 <= wb_req.dat_w;
                reg_x1:  x_reg.e1 <= wb_req.dat_w;
                reg_x2:  x_reg.e2 <= wb_req.dat_w;
                reg_y0:  y_reg.e0 <= wb_req.dat_w;
                reg_y1:  y_reg.e1 <= wb_req.dat_w;
                reg_y2:  y_reg.e2 <= wb_req.dat_w;
                default: ;
            endcase
        end
    end

    // sticky until the host writes a one to clear it.
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            overflow <= 1'b0;
        end else if (push_hit && in_full) begin
            overflow <= 1'b1;
        end else if (wr_cycle && (word == reg_status) && wb_req.dat_w[st_overflow]) begin
            overflow <= 1'b0;
        end
    end

    always_comb begin
        status               = '0;
        status[st_in_full]   = in_full;
        status[st_out_empty] = out_empty;
        status[st_overflow]  = overflow;
    end

    always_comb begin
        case (word)
            reg_x0:     rd_data = x_reg.e0;
            reg_x1:     rd_data = x_reg.e1;
            reg_x2:     rd_data = x_reg.e2;
            reg_y0:     rd_data = y_reg.e0;
            reg_y1:     rd_data = y_reg.e1;
            reg_y2:     rd_data = y_reg.e2;
            reg_status: rd_data = status;
            reg_result: rd_data = out_empty ? '0 : out_head;
            default:    rd_data = '0;
        endcase
    end

    assign wb_rsp.ack   = ack;
    assign wb_rsp.dat_r = rd_data;

    a_single_ack: assert property (@(posedge clock) disable iff (reset) ack |=> !ack)
        else $error("ack held for two cycles");

endmodule

// ==== hdl/dot_top.sv ====
`timescale 1ns/1ps

module dot_top
    import dot_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  wb_req_t wb_req,
    output wb_rsp_t wb_rsp
);

    // wires from the register block to the engine.
    logic               push_valid;
    vec_pair_t          push_pair;
    logic               in_full;
    logic               in_empty;
    logic               in_rd_en;
    vec_pair_t          in_pair;

    // wires from the engine back to the register block.
    logic signed [31:0] out_result;
    logic               out_wr_en;
    logic               out_full;
    logic               out_empty;
    logic               out_rd_en;
    logic [31:0]        out_head;

    dot_regs u_regs (
        .clock      (clock),
        .reset      (reset),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .push_valid (push_valid),
        .push_pair  (push_pair),
        .in_full    (in_full),
        .out_head   (out_head),
        .out_empty  (out_empty),
        .out_rd_en  (out_rd_en)
    );

    sync_fifo #(.payload_t(vec_pair_t), .depth(fifo_depth)) u_in_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (push_valid),
        .din   (push_pair),
        .rd_en (in_rd_en),
        .dout  (in_pair),
        .full  (in_full),
        .empty (in_empty)
    );

    dot_engine u_engine (
        .clock      (clock),
        .reset      (reset),
        .in_pair    (in_pair),
        .in_empty   (in_empty),
        .in_rd_en   (in_rd_en),
        .out_result (out_result),
        .out_full   (out_full),
        .out_wr_en  (out_wr_en)
    );

    sync_fifo #(.payload_t(logic [31:0]), .depth(fifo_depth)) u_out_fifo (
        .clock (clock),
        .reset (reset),
        .wr_en (out_wr_en),
        .din   (out_result),
        .rd_en (out_rd_en),
        .dout  (out_head),
        .full  (out_full),
        .empty (out_empty)
    );

endmodule

// ==== hdl/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo
    import dot_pkg::*;
#(
    parameter type payload_t = logic [31:0],
    parameter int  depth     = fifo_depth
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     wr_en,
    input  payload_t din,
    input  logic     rd_en,
    output payload_t dout,
    output logic     full,
    output logic     empty
);

    typedef logic [$clog2(depth)-1:0]   ptr_t;
    typedef logic [$clog2(depth+1)-1:0] count_t;

    payload_t mem [depth];
    ptr_t     wr_ptr;
    ptr_t     rd_ptr;
    count_t   count;
    count_t   count_next;
    logic     wr_ok;
    logic     rd_ok;

    // writes into a full queue are dropped.
    assign wr_ok = wr_en && !full;
    assign rd_ok = rd_en && !empty;

    always_comb begin
        count_next = count;
        case ({wr_ok, rd_ok})
            2'b10:   count_next = count + 1'b1;
            2'b01:   count_next = count - 1'b1;
            default: count_next = count;
        endcase
    end

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            full   <= 1'b0;
            empty  <= 1'b1;
        end else begin
            if (wr_ok) begin
                wr_ptr <= (wr_ptr == ptr_t'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_ok) begin
                rd_ptr <= (rd_ptr == ptr_t'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count_next;
            full  <= (count_next == count_t'(depth));
            empty <= (count_next == '0);
        end
    end

    always_ff @(posedge clock) begin
        if (wr_ok) begin
            mem[wr_ptr] <= din;
        end
    end

    // fall-through head.
    assign dout = mem[rd_ptr];

    a_no_write_full: assert property (@(posedge clock) disable iff (reset) wr_en |-> !full)
        else $error("write into full queue");

    a_no_read_empty: assert property (@(posedge clock) disable iff (reset) rd_en |-> !empty)
        else $error("read from empty queue");

endmodule

// ==== verif/dot_tb.sv ====
`timescale 1ns/1ps

module dot_tb
    import dot_pkg::*;
;

    localparam int bus_timeout  = 20;
    localparam int poll_limit   = 60;
    localparam int drain_limit  = 20;
    localparam int random_pairs = 12;
    localparam int burst_pairs  = 20;
    localparam int capacity     = 17;

    typedef struct {
        string       name;
        vec3_t       x;
        vec3_t       y;
        logic [31:0] expected;
    } case_t;

    logic        clock;
    logic        reset;
    wb_req_t     wb_req;
    wb_rsp_t     wb_rsp;
    int          errors;
    int          checks;
    logic [15:0] lfsr_state;
    case_t       cases[$];
    logic [31:0] burst_expected[$];

    dot_top dut (
        .clock  (clock),
        .reset  (reset),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    always #10 clock = ~clock;

    function automatic vec3_t make_vec(logic [31:0] e0, logic [31:0] e1, logic [31:0] e2);
        vec3_t v;
        v.e0 = e0;
        v.e1 = e1;
        v.e2 = e2;
        return v;
    endfunction

    // elementwise products are rescaled by q_bits, summed and cut to 32 bits.
    function automatic logic [31:0] dot_model(vec3_t x, vec3_t y);
        logic signed [63:0] a;
        logic signed [63:0] b;
        logic signed [63:0] acc;
        acc = '0;
        for (int i = 0; i < 3; i++) begin
            a = $signed(x[i*32 +: 32]);
            b = $signed(y[i*32 +: 32]);
            acc = acc + ((a * b) >>> q_bits);
        end
        return acc[31:0];
    endfunction

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_elem();
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < 16; i++) begin
            r = {r[14:0], lfsr_bit()};
        end
        return {{16{r[15]}}, r};
    endfunction

    function automatic vec3_t rand_vec();
        vec3_t v;
        v.e0 = rand_elem();
        v.e1 = rand_elem();
        v.e2 = rand_elem();
        return v;
    endfunction

    task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
        checks++;
        assert (actual === expected) else begin
            $display("mismatch %s: expected %h, actual %h", name, expected, actual);
            errors++;
        end
    endtask

    // starts and ends on a falling edge; request is held through the ack cycle.
    task automatic bus_cycle(logic we, logic [3:0] word, logic [31:0] wdata,
                             output logic [31:0] rdata);
        int   waited;
        logic got_ack;
        got_ack      = 1'b0;
        waited       = 0;
        rdata        = '0;
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = we;
        wb_req.adr   = {word, 2'b00};
        wb_req.dat_w = wdata;
        wb_req.sel   = 4'hf;
        while (!got_ack && waited < bus_timeout) begin
            @(negedge clock);
            waited++;
            if (wb_rsp.ack) begin
                got_ack = 1'b1;
                rdata   = wb_rsp.dat_r;
            end
        end
        if (!got_ack) begin
            $display("bus timeout: no ack for access to word %0d", word);
            errors++;
        end else begin
            @(negedge clock);
        end
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic wb_write(logic [3:0] word, logic [31:0] data);
        logic [31:0] unused;
        bus_cycle(1'b1, word, data, unused);
    endtask

    task automatic wb_read(logic [3:0] word, output logic [31:0] data);
        bus_cycle(1'b0, word, '0, data);
    endtask

    task automatic push_pair(vec3_t x, vec3_t y);
        wb_write(reg_x0, x.e0);
        wb_write(reg_x1, x.e1);
        wb_write(reg_x2, x.e2);
        wb_write(reg_y0, y.e0);
        wb_write(reg_y1, y.e1);
        wb_write(reg_y2, y.e2);
        wb_write(reg_push, 32'h1);
    endtask

    task automatic poll_result();
        logic [31:0] status;
        int          polls;
        logic        ready;
        polls = 0;
        ready = 1'b0;
        while (!ready && polls < poll_limit) begin
            wb_read(reg_status, status);
            ready = !status[st_out_empty];
            polls++;
        end
        if (!ready) begin
            $display("timeout: no result appeared in the output queue");
            errors++;
        end
    endtask

    task automatic run_pair(string name, vec3_t x, vec3_t y, logic [31:0] expected);
        logic [31:0] result;
        push_pair(x, y);
        poll_result();
        wb_read(reg_result, result);
        check_value(name, expected, result);
    endtask

    task automatic add_case(string name, logic [31:0] x0, logic [31:0] x1, logic [31:0] x2,
                            logic [31:0] y0, logic [31:0] y1, logic [31:0] y2,
                            logic [31:0] expected);
        case_t c;
        c.name     = name;
        c.x        = make_vec(x0, x1, x2);
        c.y        = make_vec(y0, y1, y2);
        c.expected = expected;
        cases.push_back(c);
    endtask

    // hand-worked values in q10 where 1.0 is 1024.
    task automatic load_cases();
        add_case("unit", 1024, 2048, 3072, 1024, 1024, 1024, 32'h0000_1800);
        add_case("mixed_sign", 1024, -2048, 512, -3072, 1024, 2048, 32'hffff_f000);
        add_case("fraction", 512, 256, 1, 512, 768, 1, 32'h0000_01c0);
        add_case("neg_floor", -1, -3, 0, 1, 1, 5, 32'hffff_fffe);
        add_case("zero", 0, 0, 0, 123456, -7, 99, 32'h0000_0000);
        add_case("wrap_pos", 32'h7fff_ffff, 32'h0010_0000, 0,
                 32'h7fff_ffff, 32'h0010_0000, 0, 32'h3fc0_0000);
        add_case("wrap_min", 32'h8000_0000, -1024, 0,
                 32'h7fff_ffff, 1024, 0, 32'h001f_fc00);
    endtask

    initial begin
        logic [31:0] data;
        logic [31:0] values[6];
        vec3_t       x;
        vec3_t       y;
        int          drained;
        clock      = 1'b0;
        reset      = 1'b1;
        wb_req     = '0;
        errors     = 0;
        checks     = 0;
        lfsr_state = 16'd4;
        values     = '{32'h1234_5678, 32'hdead_beef, 32'h0000_0400,
                       32'hffff_fc00, 32'h7fff_ffff, 32'h8000_0000};
        load_cases();
        repeat (4) @(negedge clock);
        reset = 1'b0;
        @(negedge clock);

        wb_read(reg_status, data);
        check_value("reset_status", 32'h0000_0002, data);
        wb_read(reg_result, data);
        check_value("reset_result", 32'h0, data);
        for (int i = 0; i < 6; i++) begin
            wb_read(4'(i), data);
            check_value($sformatf("reset_operand_%0d", i), 32'h0, data);
        end

        for (int i = 0; i < 6; i++) begin
            wb_write(4'(i), values[i]);
        end
        for (int i = 0; i < 6; i++) begin
            wb_read(4'(i), data);
            check_value($sformatf("readback_%0d", i), values[i], data);
        end

        foreach (cases[i]) begin
            check_value({"model_", cases[i].name}, cases[i].expected,
                        dot_model(cases[i].x, cases[i].y));
            run_pair(cases[i].name, cases[i].x, cases[i].y, cases[i].expected);
        end

        for (int i = 0; i < random_pairs; i++) begin
            x = rand_vec();
            y = rand_vec();
            run_pair($sformatf("random_%0d", i), x, y, dot_model(x, y));
        end

        // nothing is read here, so the last three pushes find the input queue full.
        for (int i = 0; i < burst_pairs; i++) begin
            x = rand_vec();
            y = rand_vec();
            burst_expected.push_back(dot_model(x, y));
            push_pair(x, y);
        end
        wb_read(reg_status, data);
        check_value("burst_status", 32'h0000_0005, data);

        drained = 0;
        wb_read(reg_status, data);
        while (!data[st_out_empty] && drained < drain_limit) begin
            wb_read(reg_result, data);
            check_value($sformatf("drain_%0d", drained), burst_expected[drained], data);
            drained++;
            wb_read(reg_status, data);
        end
        check_value("drain_count", capacity, drained);

        wb_write(reg_status, 32'h1 << st_overflow);
        wb_read(reg_status, data);
        check_value("overflow_clear", 32'h0000_0002, data);
        x = rand_vec();
        y = rand_vec();
        run_pair("after_clear", x, y, dot_model(x, y));
        wb_read(reg_status, data);
        check_value("final_status", 32'h0000_0002, data);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
hdl/dot_pkg.sv
hdl/sync_fifo.sv
hdl/dot_engine.sv
hdl/dot_regs.sv
hdl/dot_top.sv
verif/dot_tb.sv
